// File: hw/tlb_pkg.sv
`default_nettype none

package tlb_pkg;

    localparam int tlb_entries   = 16;
    localparam int tlb_idx_w     = 4;
    localparam int cache_entries = 4;
    localparam int vppn_w        = 19;
    localparam int asid_w        = 10;
    localparam int ppn_w         = 20;

    // page sizes held in ps
    localparam logic [5:0] ps_4k = 6'd12;
    localparam logic [5:0] ps_2m = 6'd21;

    typedef struct packed {
        logic              e;
        logic [vppn_w-1:0] vppn;
        logic [5:0]        ps;
        logic              g;
        logic [asid_w-1:0] asid;
        logic [ppn_w-1:0]  ppn0;
        logic [1:0]        plv0;
        logic [1:0]        mat0;
        logic              d0;
        logic              v0;
        logic [ppn_w-1:0]  ppn1;
        logic [1:0]        plv1;
        logic [1:0]        mat1;
        logic              d1;
        logic              v1;
    } tlb_entry_t;

    typedef struct packed {
        logic                 found;
        logic [tlb_idx_w-1:0] index;
        logic [ppn_w-1:0]     ppn;
        logic [5:0]           ps;
        logic [1:0]           plv;
        logic [1:0]           mat;
        logic                 d;
        logic                 v;
    } tlb_result_t;

    typedef struct packed {
        logic [vppn_w-1:0] vppn;
        logic              va_bit12;
        logic [asid_w-1:0] asid;
    } tlb_search_t;

    typedef enum logic [4:0] {
        clear_all0              = 5'd0,
        clear_all1              = 5'd1,
        clear_global            = 5'd2,
        clear_nonglobal         = 5'd3,
        clear_asid              = 5'd4,
        clear_asid_va           = 5'd5,
        clear_va_asid_or_global = 5'd6
    } invtlb_op_e;

    typedef enum logic [1:0] {
        st_cache  = 2'd0,
        st_lookup = 2'd1,
        st_fetch  = 2'd2,
        st_refill = 2'd3
    } walk_state_e;

    // huge pages ignore the low nine vppn bits
    function automatic logic vppn_match(tlb_entry_t ent, logic [vppn_w-1:0] vppn);
        if (ent.ps == ps_2m) begin
            return ent.vppn[vppn_w-1:9] == vppn[vppn_w-1:9];
        end
        return ent.vppn == vppn;
    endfunction

    function automatic logic entry_match(tlb_entry_t ent, tlb_search_t key);
        return ent.e && (ent.g || ent.asid == key.asid) && vppn_match(ent, key.vppn);
    endfunction

    // even/odd half selection
    function automatic tlb_result_t make_result(tlb_entry_t ent, tlb_search_t key,
                                                logic found, logic [tlb_idx_w-1:0] index);
        tlb_result_t res;
        logic        even;
        even = (ent.ps == ps_4k && !key.va_bit12) || (ent.ps == ps_2m && !key.vppn[8]);
        res.found = found;
        res.index = index;
        res.ps    = ent.ps;
        res.ppn   = even ? ent.ppn0 : ent.ppn1;
        res.plv   = even ? ent.plv0 : ent.plv1;
        res.mat   = even ? ent.mat0 : ent.mat1;
        res.d     = even ? ent.d0 : ent.d1;
        res.v     = even ? ent.v0 : ent.v1;
        return res;
    endfunction

endpackage

`default_nettype wire

// File: hw/tlb_main.sv
`timescale 1ns/100ps
`default_nettype none

module tlb_main (
    input  wire logic                            clk,
    input  wire logic                            reset,

    input  tlb_pkg::tlb_search_t                 s0_key,
    input  tlb_pkg::tlb_search_t                 s1_key,
    output logic                                 s0_hit,
    output logic                                 s1_hit,
    output logic [tlb_pkg::tlb_idx_w-1:0]        s0_index,
    output logic [tlb_pkg::tlb_idx_w-1:0]        s1_index,
    output tlb_pkg::tlb_entry_t                  s0_entry,
    output tlb_pkg::tlb_entry_t                  s1_entry,

    input  wire logic                            we,
    input  wire logic [tlb_pkg::tlb_idx_w-1:0]   w_index,
    input  tlb_pkg::tlb_entry_t                  w_entry,

    input  wire logic [tlb_pkg::tlb_idx_w-1:0]   r_index,
    output tlb_pkg::tlb_entry_t                  r_entry,

    input  wire logic                            invtlb_valid,
    input  tlb_pkg::invtlb_op_e                  invtlb_op,
    input  wire logic [tlb_pkg::asid_w-1:0]      invtlb_asid,
    input  wire logic [31:0]                     invtlb_va
);

    tlb_pkg::tlb_entry_t  tlb_q [tlb_pkg::tlb_entries];
    tlb_pkg::tlb_search_t key_q [2];

    logic                          hit [2];
    logic [tlb_pkg::tlb_idx_w-1:0] idx [2];

    // invtlb clearing rule for one entry
    function automatic logic inv_hit(tlb_pkg::tlb_entry_t ent);
        logic asid_eq;
        logic va_eq;
        asid_eq = ent.asid == invtlb_asid;
        va_eq   = tlb_pkg::vppn_match(ent, invtlb_va[31:13]);
        case (invtlb_op)
            tlb_pkg::clear_all0,
            tlb_pkg::clear_all1:              return 1'b1;
            tlb_pkg::clear_global:            return ent.g;
            tlb_pkg::clear_nonglobal:         return !ent.g;
            tlb_pkg::clear_asid:              return !ent.g && asid_eq;
            tlb_pkg::clear_asid_va:           return !ent.g && asid_eq && va_eq;
            tlb_pkg::clear_va_asid_or_global: return (ent.g || asid_eq) && va_eq;
            default:                          return 1'b0;
        endcase
    endfunction

    // one-cycle lookup
    always_ff @(posedge clk) begin
        key_q[0] <= s0_key;
        key_q[1] <= s1_key;
    end

    // lowest matching index wins
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            hit[p] = 1'b0;
            idx[p] = '0;
            for (int i = tlb_pkg::tlb_entries - 1; i >= 0; i--) begin
                if (tlb_pkg::entry_match(tlb_q[i], key_q[p])) begin
                    hit[p] = 1'b1;
                    idx[p] = i[tlb_pkg::tlb_idx_w-1:0];
                end
            end
        end
    end

    assign s0_hit   = hit[0];
    assign s1_hit   = hit[1];
    assign s0_index = idx[0];
    assign s1_index = idx[1];
    assign s0_entry = tlb_q[idx[0]];
    assign s1_entry = tlb_q[idx[1]];

    assign r_entry = tlb_q[r_index];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < tlb_pkg::tlb_entries; i++) begin
                tlb_q[i].e <= 1'b0;
            end
        end else begin
            if (invtlb_valid) begin
                for (int i = 0; i < tlb_pkg::tlb_entries; i++) begin
                    if (inv_hit(tlb_q[i])) begin
                        tlb_q[i].e <= 1'b0;
                    end
                end
            end
            // a write in the same cycle takes precedence
            if (we) begin
                tlb_q[w_index] <= w_entry;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/tlb_port_cache.sv
`timescale 1ns/100ps
`default_nettype none

module tlb_port_cache (
    input  wire logic                          clk,
    input  wire logic                          reset,

    input  tlb_pkg::tlb_search_t               key,
    output tlb_pkg::tlb_result_t               result,

    input  wire logic                          refill,
    input  wire logic [tlb_pkg::tlb_idx_w-1:0] refill_index,
    input  tlb_pkg::tlb_entry_t                refill_entry,
    input  wire logic                          flush
);

    logic [tlb_pkg::cache_entries-1:0] slot_valid_q;
    tlb_pkg::tlb_entry_t               slot_entry_q [tlb_pkg::cache_entries];
    logic [tlb_pkg::tlb_idx_w-1:0]     slot_index_q [tlb_pkg::cache_entries];

    logic [$clog2(tlb_pkg::cache_entries)-1:0] victim_q;
    logic [$clog2(tlb_pkg::cache_entries)-1:0] sel;
    logic                                      any_hit;

    // combinational lookup over all slots
    always_comb begin
        any_hit = 1'b0;
        sel     = '0;
        for (int i = tlb_pkg::cache_entries - 1; i >= 0; i--) begin
            if (slot_valid_q[i] && tlb_pkg::entry_match(slot_entry_q[i], key)) begin
                any_hit = 1'b1;
                sel     = i[$clog2(tlb_pkg::cache_entries)-1:0];
            end
        end
    end

    assign result = tlb_pkg::make_result(slot_entry_q[sel], key, any_hit, slot_index_q[sel]);

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_valid_q <= '0;
            victim_q     <= '0;
        end else if (flush) begin
            slot_valid_q <= '0;
        end else if (refill) begin
            slot_valid_q[victim_q] <= 1'b1;
            victim_q               <= victim_q + 1'b1;
        end
    end

    // slot payload
    always_ff @(posedge clk) begin
        if (refill && !flush) begin
            slot_entry_q[victim_q] <= refill_entry;
            slot_index_q[victim_q] <= refill_index;
        end
    end

endmodule

`default_nettype wire

// File: hw/tlb_miss_walker.sv
`timescale 1ns/100ps
`default_nettype none

module tlb_miss_walker (
    input  wire logic                          clk,
    input  wire logic                          reset,

    input  tlb_pkg::tlb_search_t               req,
    input  wire logic                          valid,

    output tlb_pkg::tlb_search_t               cache_key,
    input  tlb_pkg::tlb_result_t               cache_result,

    output tlb_pkg::tlb_search_t               main_key,
    input  wire logic                          main_hit,
    input  wire logic [tlb_pkg::tlb_idx_w-1:0] main_index,
    input  tlb_pkg::tlb_entry_t                main_entry,

    output logic                               refill,
    output logic [tlb_pkg::tlb_idx_w-1:0]      refill_index,
    output tlb_pkg::tlb_entry_t                refill_entry,
    input  wire logic                          flush,

    output tlb_pkg::tlb_result_t               result,
    output logic                               ok
);

    tlb_pkg::walk_state_e state_q;
    tlb_pkg::walk_state_e state_d;

    tlb_pkg::tlb_search_t          key_q;
    logic                          walk_hit_q;
    logic                          walk_fill_q;
    logic [tlb_pkg::tlb_idx_w-1:0] walk_index_q;
    tlb_pkg::tlb_entry_t           walk_entry_q;
    tlb_pkg::tlb_result_t          walk_result;

    always_comb begin
        state_d = state_q;
        case (state_q)
            tlb_pkg::st_cache: begin
                if (valid && !cache_result.found) begin
                    state_d = tlb_pkg::st_lookup;
                end
            end
            tlb_pkg::st_lookup: state_d = valid ? tlb_pkg::st_fetch : tlb_pkg::st_cache;
            tlb_pkg::st_fetch:  state_d = valid ? tlb_pkg::st_refill : tlb_pkg::st_cache;
            default:            state_d = tlb_pkg::st_cache;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q     <= tlb_pkg::st_cache;
            walk_fill_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // an entry sampled across a write may be stale
            if (state_q == tlb_pkg::st_fetch) begin
                walk_fill_q <= main_hit && !flush;
            end
        end
    end

    // key held for the whole walk
    always_ff @(posedge clk) begin
        if (state_q == tlb_pkg::st_cache) begin
            key_q <= req;
        end
        if (state_q == tlb_pkg::st_fetch) begin
            walk_hit_q   <= main_hit;
            walk_index_q <= main_index;
            walk_entry_q <= main_entry;
        end
    end

    assign cache_key = req;
    assign main_key  = key_q;

    assign walk_result = tlb_pkg::make_result(walk_entry_q, key_q, walk_hit_q, walk_index_q);

    assign refill       = state_q == tlb_pkg::st_refill && walk_fill_q && !flush;
    assign refill_index = walk_index_q;
    assign refill_entry = walk_entry_q;

    assign result = (state_q == tlb_pkg::st_cache) ? cache_result : walk_result;
    // cache hit answers in the request cycle
    assign ok = (state_q == tlb_pkg::st_cache && valid && cache_result.found)
              || state_q == tlb_pkg::st_refill;

endmodule

`default_nettype wire

// File: hw/tlb_top.sv
`timescale 1ns/100ps
`default_nettype none

module tlb_top (
    input  wire logic                          clk,
    input  wire logic                          reset,

    // fetch port
    input  tlb_pkg::tlb_search_t               s0_req,
    input  wire logic                          s0_valid,
    output tlb_pkg::tlb_result_t               s0_result,
    output logic                               s0_ok,

    // load/store port
    input  tlb_pkg::tlb_search_t               s1_req,
    input  wire logic                          s1_valid,
    output tlb_pkg::tlb_result_t               s1_result,
    output logic                               s1_ok,

    input  wire logic                          we,
    input  wire logic [tlb_pkg::tlb_idx_w-1:0] w_index,
    input  tlb_pkg::tlb_entry_t                w_entry,

    input  wire logic [tlb_pkg::tlb_idx_w-1:0] r_index,
    output tlb_pkg::tlb_entry_t                r_entry,

    input  wire logic                          invtlb_valid,
    input  tlb_pkg::invtlb_op_e                invtlb_op,
    input  wire logic [tlb_pkg::asid_w-1:0]    invtlb_asid,
    input  wire logic [31:0]                   invtlb_va
);

    logic                          flush;
    tlb_pkg::tlb_search_t          cache_key [2];
    tlb_pkg::tlb_result_t          cache_res [2];
    tlb_pkg::tlb_search_t          main_key [2];
    logic                          main_hit [2];
    logic [tlb_pkg::tlb_idx_w-1:0] main_index [2];
    tlb_pkg::tlb_entry_t           main_entry [2];
    logic                          refill [2];
    logic [tlb_pkg::tlb_idx_w-1:0] refill_index [2];
    tlb_pkg::tlb_entry_t           refill_entry [2];

    // caches never outlive a change to the main TLB
    assign flush = we | invtlb_valid;

    tlb_port_cache i_cache0 (
        .clk(clk), .reset(reset), .key(cache_key[0]), .result(cache_res[0]),
        .refill(refill[0]), .refill_index(refill_index[0]),
        .refill_entry(refill_entry[0]), .flush(flush)
    );

    tlb_port_cache i_cache1 (
        .clk(clk), .reset(reset), .key(cache_key[1]), .result(cache_res[1]),
        .refill(refill[1]), .refill_index(refill_index[1]),
        .refill_entry(refill_entry[1]), .flush(flush)
    );

    tlb_miss_walker i_walk0 (
        .clk(clk), .reset(reset), .req(s0_req), .valid(s0_valid),
        .cache_key(cache_key[0]), .cache_result(cache_res[0]),
        .main_key(main_key[0]), .main_hit(main_hit[0]),
        .main_index(main_index[0]), .main_entry(main_entry[0]),
        .refill(refill[0]), .refill_index(refill_index[0]),
        .refill_entry(refill_entry[0]), .flush(flush),
        .result(s0_result), .ok(s0_ok)
    );

    tlb_miss_walker i_walk1 (
        .clk(clk), .reset(reset), .req(s1_req), .valid(s1_valid),
        .cache_key(cache_key[1]), .cache_result(cache_res[1]),
        .main_key(main_key[1]), .main_hit(main_hit[1]),
        .main_index(main_index[1]), .main_entry(main_entry[1]),
        .refill(refill[1]), .refill_index(refill_index[1]),
        .refill_entry(refill_entry[1]), .flush(flush),
        .result(s1_result), .ok(s1_ok)
    );

    tlb_main i_main (
        .clk(clk), .reset(reset),
        .s0_key(main_key[0]), .s1_key(main_key[1]),
        .s0_hit(main_hit[0]), .s1_hit(main_hit[1]),
        .s0_index(main_index[0]), .s1_index(main_index[1]),
        .s0_entry(main_entry[0]), .s1_entry(main_entry[1]),
        .we(we), .w_index(w_index), .w_entry(w_entry),
        .r_index(r_index), .r_entry(r_entry),
        .invtlb_valid(invtlb_valid), .invtlb_op(invtlb_op),
        .invtlb_asid(invtlb_asid), .invtlb_va(invtlb_va)
    );

endmodule

`default_nettype wire

// File: dv/tlb_checker.sv
`timescale 1ns/100ps
`default_nettype none

module tlb_checker (
    input  wire logic           clk,
    input  wire logic           s0_ok,
    input  wire logic           s1_ok,
    input  tlb_pkg::tlb_result_t s0_result,
    input  tlb_pkg::tlb_result_t s1_result,
    input  wire logic           refill0,
    input  wire logic           refill1,
    input  tlb_pkg::tlb_result_t exp0,
    input  tlb_pkg::tlb_result_t exp1,
    input  wire logic           armed0,
    input  wire logic           armed1,
    input  tlb_pkg::tlb_entry_t r_entry,
    input  tlb_pkg::tlb_entry_t exp_r,
    input  wire logic           r_check
);

    int checks;
    int errors;
    int test_checks;
    int test_errors;

    task automatic value_error(input string sig, input logic [88:0] exp, input logic [88:0] act);
        errors++;
        test_errors++;
        $display("FAILED t=%0t %s expected %h got %h", $time, sig, exp, act);
    endtask

    task automatic plain_error(input string msg);
        errors++;
        test_errors++;
        $display("error at t=%0t: %s", $time, msg);
    endtask

    task automatic finish_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic print_totals();
        $display("total: %0d checks, %0d errors", checks, errors);
    endtask

    // not-found results only carry a meaningful found bit
    task automatic check_port(input string sig, input logic armed, input logic ok,
                              input logic refill, input tlb_pkg::tlb_result_t exp,
                              input tlb_pkg::tlb_result_t act);
        if (ok) begin
            checks++;
            test_checks++;
            if (!armed) begin
                plain_error({sig, " signalled ok with no search pending"});
            end else if (exp.found && act !== exp) begin
                value_error(sig, {53'd0, exp}, {53'd0, act});
            end else if (!exp.found && act.found !== 1'b0) begin
                value_error({sig, ".found"}, 89'd0, {88'd0, act.found});
            end
            if (armed && !exp.found && refill) begin
                plain_error({sig, " refilled its cache after a main TLB miss"});
            end
        end
    endtask

    always @(negedge clk) begin
        check_port("s0_result", armed0, s0_ok, refill0, exp0, s0_result);
        check_port("s1_result", armed1, s1_ok, refill1, exp1, s1_result);
        if (r_check) begin
            checks++;
            test_checks++;
            if (r_entry !== exp_r) begin
                value_error("r_entry", exp_r, r_entry);
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tlb_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module tlb_assertions (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire logic          valid,
    input  wire logic          ok,
    input  wire logic          refill,
    input  wire logic          found,
    input  wire logic          cache_found,
    input  tlb_pkg::walk_state_e state
);

    // an answer always ends the walk
    ok_ends_walk: assert property (@(posedge clk) disable iff (reset)
        ok |=> state == tlb_pkg::st_cache)
        else $error("walker still busy in the cycle after ok");

    refill_found: assert property (@(posedge clk) disable iff (reset)
        refill |-> ok && found)
        else $error("refill without an answered main TLB hit");

    // lookup, fetch, then refill
    miss_latency: assert property (@(posedge clk) disable iff (reset)
        $past(state == tlb_pkg::st_cache && valid && !cache_found, 3)
            && $past(valid, 2) && $past(valid) |-> ok)
        else $error("ok did not follow a held miss by three cycles");

endmodule

bind tlb_miss_walker tlb_assertions i_asrt (
    .clk(clk), .reset(reset), .valid(valid), .ok(ok), .refill(refill),
    .found(result.found), .cache_found(cache_result.found), .state(state_q)
);

`default_nettype wire

// File: dv/tlb_tb.sv
`timescale 1ns/100ps
`default_nettype none

module tlb_tb;

    localparam int num_ops = 450;

    logic                 clk;
    logic                 reset;
    tlb_pkg::tlb_search_t s0_req;
    tlb_pkg::tlb_search_t s1_req;
    logic                 s0_valid;
    logic                 s1_valid;
    tlb_pkg::tlb_result_t s0_result;
    tlb_pkg::tlb_result_t s1_result;
    logic                 s0_ok;
    logic                 s1_ok;
    logic                 we;
    logic [3:0]           w_index;
    tlb_pkg::tlb_entry_t  w_entry;
    logic [3:0]           r_index;
    tlb_pkg::tlb_entry_t  r_entry;
    logic                 invtlb_valid;
    tlb_pkg::invtlb_op_e  invtlb_op;
    logic [9:0]           invtlb_asid;
    logic [31:0]          invtlb_va;
    tlb_pkg::tlb_result_t exp0;
    tlb_pkg::tlb_result_t exp1;
    logic                 armed0;
    logic                 armed1;
    tlb_pkg::tlb_entry_t  exp_r;
    logic                 r_check;
    integer               seed;

    // reference TLB and per-port cache model
    tlb_pkg::tlb_entry_t model_q [16];
    logic [3:0]          slot_idx [2][4];
    logic                slot_vld [2][4];
    int                  slot_ptr [2];

    tlb_top i_dut (
        .clk(clk), .reset(reset),
        .s0_req(s0_req), .s0_valid(s0_valid), .s0_result(s0_result), .s0_ok(s0_ok),
        .s1_req(s1_req), .s1_valid(s1_valid), .s1_result(s1_result), .s1_ok(s1_ok),
        .we(we), .w_index(w_index), .w_entry(w_entry),
        .r_index(r_index), .r_entry(r_entry),
        .invtlb_valid(invtlb_valid), .invtlb_op(invtlb_op),
        .invtlb_asid(invtlb_asid), .invtlb_va(invtlb_va)
    );

    tlb_checker i_chk (
        .clk(clk), .s0_ok(s0_ok), .s1_ok(s1_ok), .s0_result(s0_result),
        .s1_result(s1_result), .refill0(i_dut.i_walk0.refill),
        .refill1(i_dut.i_walk1.refill), .exp0(exp0), .exp1(exp1),
        .armed0(armed0), .armed1(armed1), .r_entry(r_entry), .exp_r(exp_r),
        .r_check(r_check)
    );

    always #4 clk = ~clk;

    initial begin
        #(num_ops * 20 * 8);
        $display("timeout: the tests did not finish in the expected time");
        $display("TEST FAILED");
        $finish;
    end

    function automatic logic rule_match(tlb_pkg::tlb_entry_t ent, tlb_pkg::tlb_search_t key);
        logic vppn_eq;
        if (ent.ps == 6'd21) begin
            vppn_eq = ent.vppn[18:9] == key.vppn[18:9];
        end else begin
            vppn_eq = ent.vppn == key.vppn;
        end
        return ent.e && (ent.g || ent.asid == key.asid) && vppn_eq;
    endfunction

    function automatic tlb_pkg::tlb_result_t predict(tlb_pkg::tlb_search_t key);
        tlb_pkg::tlb_result_t res;
        tlb_pkg::tlb_entry_t  ent;
        logic                 odd;
        res = '0;
        for (int i = 15; i >= 0; i--) begin
            if (rule_match(model_q[i], key)) begin
                res.found = 1'b1;
                res.index = i[3:0];
            end
        end
        ent = model_q[res.index];
        odd = (ent.ps == 6'd21) ? key.vppn[8] : key.va_bit12;
        res.ps  = ent.ps;
        res.ppn = odd ? ent.ppn1 : ent.ppn0;
        res.plv = odd ? ent.plv1 : ent.plv0;
        res.mat = odd ? ent.mat1 : ent.mat0;
        res.d   = odd ? ent.d1 : ent.d0;
        res.v   = odd ? ent.v1 : ent.v0;
        return res;
    endfunction

    function automatic logic cached(int p, tlb_pkg::tlb_search_t key);
        for (int s = 0; s < 4; s++) begin
            if (slot_vld[p][s] && rule_match(model_q[slot_idx[p][s]], key)) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // vppn bits 12:9 carry the index so no two entries overlap
    function automatic tlb_pkg::tlb_entry_t new_entry(logic [3:0] idx);
        tlb_pkg::tlb_entry_t ent;
        logic [31:0]         r;
        r = $random(seed);
        ent = 89'({$random(seed), $random(seed), $random(seed)});
        ent.e    = 1'b1;
        ent.vppn = {1'b0, r[4:0], idx, r[13:5]};
        ent.ps   = r[14] ? 6'd21 : 6'd12;
        ent.g    = r[16:15] == 2'b00;
        return ent;
    endfunction

    function automatic tlb_pkg::tlb_search_t make_key(logic [3:0] idx);
        tlb_pkg::tlb_search_t key;
        logic [31:0]          r;
        r = $random(seed);
        key.vppn = model_q[idx].vppn;
        if (model_q[idx].ps == 6'd21) begin
            key.vppn[8:0] = r[8:0];
        end
        key.va_bit12 = r[9];
        key.asid     = model_q[idx].g ? r[19:10] : model_q[idx].asid;
        return key;
    endfunction

    task automatic flush_model();
        for (int p = 0; p < 2; p++) begin
            for (int s = 0; s < 4; s++) begin
                slot_vld[p][s] = 1'b0;
            end
        end
    endtask

    task automatic set_port(input int p, input tlb_pkg::tlb_search_t key, input logic v,
                            input tlb_pkg::tlb_result_t exp);
        if (p == 0) begin
            s0_req   = key;
            s0_valid = v;
            exp0     = exp;
            armed0   = v;
        end else begin
            s1_req   = key;
            s1_valid = v;
            exp1     = exp;
            armed1   = v;
        end
    endtask

    task automatic write_entry(input logic [3:0] idx, input tlb_pkg::tlb_entry_t ent);
        @(posedge clk);
        #1;
        we      = 1'b1;
        w_index = idx;
        w_entry = ent;
        @(posedge clk);
        #1;
        we            = 1'b0;
        model_q[idx]  = ent;
        flush_model();
        r_index = idx;
        exp_r   = ent;
        r_check = 1'b1;
        @(posedge clk);
        #1;
        r_check = 1'b0;
    endtask

    task automatic do_invtlb(input tlb_pkg::invtlb_op_e op, input logic [9:0] asid,
                             input logic [31:0] va);
        logic asid_eq;
        logic va_eq;
        logic clr;
        @(posedge clk);
        #1;
        invtlb_valid = 1'b1;
        invtlb_op    = op;
        invtlb_asid  = asid;
        invtlb_va    = va;
        @(posedge clk);
        #1;
        invtlb_valid = 1'b0;
        for (int i = 0; i < 16; i++) begin
            asid_eq = model_q[i].asid == asid;
            va_eq   = (model_q[i].ps == 6'd21) ? model_q[i].vppn[18:9] == va[31:22]
                                               : model_q[i].vppn == va[31:13];
            case (op)
                tlb_pkg::clear_global:            clr = model_q[i].g;
                tlb_pkg::clear_nonglobal:         clr = !model_q[i].g;
                tlb_pkg::clear_asid:              clr = !model_q[i].g && asid_eq;
                tlb_pkg::clear_asid_va:           clr = !model_q[i].g && asid_eq && va_eq;
                tlb_pkg::clear_va_asid_or_global: clr = (model_q[i].g || asid_eq) && va_eq;
                default:                          clr = 1'b1;
            endcase
            if (clr) begin
                model_q[i].e = 1'b0;
            end
        end
        flush_model();
    endtask

    // abandon 1 drops valid in st_lookup, 2 in st_fetch
    task automatic do_search(input int p, input tlb_pkg::tlb_search_t key, input int abandon);
        tlb_pkg::tlb_result_t exp;
        int                   exp_lat;
        int                   lat;
        logic                 got;
        logic                 dropped;
        exp     = predict(key);
        exp_lat = cached(p, key) ? 0 : 3;
        lat     = 0;
        got     = 1'b0;
        dropped = 1'b0;
        @(posedge clk);
        #1;
        set_port(p, key, 1'b1, exp);
        while (!got && !dropped && lat <= 8) begin
            @(negedge clk);
            if ((p == 0) ? s0_ok : s1_ok) begin
                got = 1'b1;
            end else if (abandon != 0 && lat + 1 == abandon) begin
                dropped = 1'b1;
            end else begin
                lat++;
            end
        end
        @(posedge clk);
        #1;
        set_port(p, key, 1'b0, exp);
        if (got) begin
            if (lat != exp_lat) begin
                i_chk.value_error((p == 0) ? "s0_ok latency" : "s1_ok latency",
                                  89'(exp_lat), 89'(lat));
            end
            if (exp_lat != 0 && exp.found) begin
                slot_idx[p][slot_ptr[p]] = exp.index;
                slot_vld[p][slot_ptr[p]] = 1'b1;
                slot_ptr[p] = (slot_ptr[p] + 1) % 4;
            end
        end else if (dropped) begin
            repeat (3) @(posedge clk);
        end else begin
            i_chk.plain_error($sformatf("search on port %0d never got ok", p));
        end
    endtask

    initial begin
        tlb_pkg::tlb_search_t k0;
        tlb_pkg::tlb_search_t k1;
        int                   j;
        clk          = 1'b0;
        reset        = 1'b1;
        s0_req       = '0;
        s1_req       = '0;
        s0_valid     = 1'b0;
        s1_valid     = 1'b0;
        we           = 1'b0;
        w_index      = '0;
        w_entry      = '0;
        r_index      = '0;
        invtlb_valid = 1'b0;
        invtlb_op    = tlb_pkg::clear_all0;
        invtlb_asid  = '0;
        invtlb_va    = '0;
        exp0         = '0;
        exp1         = '0;
        armed0       = 1'b0;
        armed1       = 1'b0;
        exp_r        = '0;
        r_check      = 1'b0;
        seed         = 32'hbdce;
        slot_ptr     = '{0, 0};
        for (int i = 0; i < 16; i++) begin
            model_q[i] = '0;
        end
        flush_model();
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < 40; i++) begin
            j = (i < 16) ? i : ($random(seed) & 15);
            write_entry(j[3:0], new_entry(j[3:0]));
        end
        i_chk.finish_test("write and read back");

        for (int i = 0; i < 8; i++) begin
            k0 = {1'b1, 29'($random(seed))};
            do_search($random(seed) & 1, k0, 0);
        end
        i_chk.finish_test("absent addresses");

        for (int i = 0; i < 40; i++) begin
            do_search($random(seed) & 1, make_key(4'($random(seed))), 0);
        end
        i_chk.finish_test("random searches");

        for (int i = 0; i < 20; i++) begin
            j  = $random(seed) & 1;
            k0 = make_key(4'($random(seed)));
            do_search(j, k0, 0);
            do_search(j, k0, 0);
        end
        i_chk.finish_test("repeated searches");

        for (int op = 0; op < 7; op++) begin
            for (int i = 0; i < 16; i++) begin
                write_entry(i[3:0], new_entry(i[3:0]));
            end
            for (int i = 0; i < 8; i++) begin
                do_search($random(seed) & 1, make_key(4'($random(seed))), 0);
            end
            j = $random(seed) & 15;
            do_invtlb(tlb_pkg::invtlb_op_e'(op),
                      ($random(seed) & 1) ? model_q[j].asid : 10'($random(seed)),
                      {model_q[j].vppn, 13'($random(seed))});
            for (int i = 0; i < 16; i++) begin
                do_search($random(seed) & 1, make_key(i[3:0]), 0);
            end
        end
        i_chk.finish_test("invtlb opcodes");

        for (int i = 0; i < 30; i++) begin
            k0 = ($random(seed) & 3) == 0 ? {1'b1, 29'($random(seed))}
                                          : make_key(4'($random(seed)));
            k1 = make_key(4'($random(seed)));
            fork
                do_search(0, k0, $unsigned($random(seed)) % 3);
                do_search(1, k1, $unsigned($random(seed)) % 3);
            join
        end
        i_chk.finish_test("dual port with abandon");

        i_chk.print_totals();
        if (i_chk.errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
hw/tlb_pkg.sv
hw/tlb_main.sv
hw/tlb_port_cache.sv
hw/tlb_miss_walker.sv
hw/tlb_top.sv
dv/tlb_checker.sv
dv/tlb_assertions.sv
dv/tlb_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tlb_tb
FILELIST = all.f
LOG      = sim.log

.PHONY: compile run clean

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
